/* fpu_pkg.sv */
/*
  Floating-point coprocessor definitions
  Operation codes, APB register offsets, single-precision field widths
  and the operand and raw-result records passed between the blocks
*/

package fpu_pkg;

  // ************************************************************************
  // Command and register map
  // ************************************************************************

  // Code 3 is rejected by the register block
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2
  } fpu_op_e;

  // Word offsets
  localparam int unsigned REG_CMD     = 0;
  localparam int unsigned REG_OPERAND = 1;
  localparam int unsigned REG_STATUS  = 2;
  localparam int unsigned REG_RESULT  = 3;

  // ************************************************************************
  // Single-precision format
  // ************************************************************************

  localparam int EXP_BIAS   = 127;
  localparam int BW_EXP     = 8;
  localparam int BW_MANT    = 23;
  localparam int BW_SIG     = 24;

  // Raw magnitude has its binary point after bit 46, bit 47 takes a carry
  localparam int BW_RAW     = 48;
  localparam int BW_RAW_EXP = 10;

  // Operand with the hidden one made explicit
  typedef struct packed {
    logic              sign;
    logic [BW_EXP-1:0] exp;
    logic [BW_SIG-1:0] sig;
  } fp_unpacked_t;

  // Value is mag * 2**(exp - EXP_BIAS - 46)
  typedef struct packed {
    logic                  sign;
    logic [BW_RAW_EXP-1:0] exp;
    logic [BW_RAW-1:0]     mag;
  } fp_raw_t;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_EXEC = 2'd1,
    ST_PACK = 2'd2,
    ST_DONE = 2'd3
  } fpu_state_e;

endpackage

/* fpu_apb_regs.sv */
/*
  FPU register block
  APB decode, command and operand registers, the four-state sequencer
  and the result register. RESULT reads stall while a computation runs
*/

module fpu_apb_regs #(
  parameter int BW_ADDR = 4
) (
  input  logic                 clk,
  input  logic                 rstnn,
  input  logic                 i_psel,
  input  logic                 i_penable,
  input  logic [BW_ADDR-1:0]   i_paddr,
  input  logic                 i_pwrite,
  input  logic [31:0]          i_pwdata,
  output logic [31:0]          o_prdata,
  output logic                 o_pready,
  output logic                 o_pslverr,
  input  logic [31:0]          i_packed,
  output fpu_pkg::fpu_op_e     o_op,
  output fpu_pkg::fp_unpacked_t o_op_a,
  output fpu_pkg::fp_unpacked_t o_op_b,
  output logic                 o_start
);

  import fpu_pkg::*;

  fpu_state_e   state;
  fpu_op_e      op;
  logic         operand_cnt;
  fp_unpacked_t op_a;
  fp_unpacked_t op_b;
  fp_unpacked_t wdata_unpacked;
  logic [31:0]  result;

  logic sel_cmd;
  logic sel_operand;
  logic sel_status;
  logic sel_result;
  logic unmapped;
  logic busy;
  logic access;
  logic cmd_illegal;
  logic cmd_wr;
  logic operand_wr;
  logic result_rd;

  // ************************************************************************
  // Decode
  // ************************************************************************

  assign sel_cmd     = (i_paddr == BW_ADDR'(REG_CMD));
  assign sel_operand = (i_paddr == BW_ADDR'(REG_OPERAND));
  assign sel_status  = (i_paddr == BW_ADDR'(REG_STATUS));
  assign sel_result  = (i_paddr == BW_ADDR'(REG_RESULT));
  assign unmapped    = !(sel_cmd || sel_operand || sel_status || sel_result);

  assign busy        = (state == ST_EXEC) || (state == ST_PACK);
  assign access      = i_psel && i_penable;
  assign cmd_illegal = sel_cmd && i_pwrite && (i_pwdata[1:0] == 2'd3);

  assign cmd_wr     = access && i_pwrite && sel_cmd && !cmd_illegal;
  assign operand_wr = access && i_pwrite && sel_operand;
  assign result_rd  = access && !i_pwrite && sel_result && !busy;

  // Only a RESULT read during a computation waits
  assign o_pready  = !(i_psel && !i_pwrite && sel_result && busy);
  assign o_pslverr = access && (unmapped || cmd_illegal);

  always_comb
  begin
    o_prdata = '0;
    if (sel_cmd)
      o_prdata = {30'd0, op};
    else if (sel_status)
      o_prdata = {31'd0, busy};
    else if (sel_result)
      o_prdata = result;
  end

  // Hidden one is added on the way in
  assign wdata_unpacked = '{sign: i_pwdata[31],
                            exp:  i_pwdata[30:BW_MANT],
                            sig:  {1'b1, i_pwdata[BW_MANT-1:0]}};

  // ************************************************************************
  // Command and operands
  // ************************************************************************

  always_ff @(posedge clk, negedge rstnn)
  begin
    if (rstnn == 1'b0)
    begin
      op          <= OP_ADD;
      operand_cnt <= 1'b0;
      op_a        <= '0;
      op_b        <= '0;
    end
    else if (cmd_wr)
    begin
      op          <= fpu_op_e'(i_pwdata[1:0]);
      operand_cnt <= 1'b0;
    end
    else if (operand_wr)
    begin
      if (operand_cnt == 1'b0)
        op_a <= wdata_unpacked;
      else
        op_b <= wdata_unpacked;
      operand_cnt <= !operand_cnt;
    end
  end

  // ************************************************************************
  // Sequencer and result
  // ************************************************************************

  always_ff @(posedge clk, negedge rstnn)
  begin
    if (rstnn == 1'b0)
      state <= ST_IDLE;
    else if (cmd_wr)
      state <= ST_IDLE;
    else if (operand_wr && operand_cnt)
      state <= ST_EXEC;
    else
      case (state)
        ST_EXEC: state <= ST_PACK;
        ST_PACK: state <= ST_DONE;
        ST_DONE:
          if (result_rd)
            state <= ST_IDLE;
        default: state <= state;
      endcase
  end

  always_ff @(posedge clk, negedge rstnn)
  begin
    if (rstnn == 1'b0)
      result <= '0;
    else if (state == ST_PACK)
      result <= i_packed;
  end

  // ST_EXEC lasts exactly one cycle
  assign o_start = (state == ST_EXEC);
  assign o_op    = op;
  assign o_op_a  = op_a;
  assign o_op_b  = op_b;

endmodule

/* fpu_add_path.sv */
/*
  FPU add/subtract path
  Orders the operands, aligns the smaller significand and adds or
  subtracts the magnitudes into a raw result register
*/

module fpu_add_path (
  input  logic                  clk,
  input  logic                  rstnn,
  input  logic                  i_start,
  input  fpu_pkg::fpu_op_e      i_op,
  input  fpu_pkg::fp_unpacked_t i_op_a,
  input  fpu_pkg::fp_unpacked_t i_op_b,
  output fpu_pkg::fp_raw_t      o_raw
);

  import fpu_pkg::*;

  fp_unpacked_t      b_eff;
  fp_unpacked_t      big;
  fp_unpacked_t      little;
  logic              a_is_big;
  logic [BW_EXP-1:0] exp_diff;
  logic [BW_RAW-1:0] big_mag;
  logic [BW_RAW-1:0] small_mag;
  logic [BW_RAW-1:0] sum_mag;

  // Subtraction is addition of a negated B
  always_comb
  begin
    b_eff = i_op_b;
    if (i_op == OP_SUB)
      b_eff.sign = !i_op_b.sign;
  end

  assign a_is_big = (i_op_a.exp > b_eff.exp) ||
                    ((i_op_a.exp == b_eff.exp) && (i_op_a.sig >= b_eff.sig));
  assign big      = a_is_big ? i_op_a : b_eff;
  assign little   = a_is_big ? b_eff  : i_op_a;
  assign exp_diff = big.exp - little.exp;

  // Larger significand sits at bits 46..23, shifted-out bits are lost
  assign big_mag   = {1'b0, big.sig, {BW_MANT{1'b0}}};
  assign small_mag = {1'b0, little.sig, {BW_MANT{1'b0}}} >> exp_diff;

  // Ordering keeps the difference non-negative
  assign sum_mag = (big.sign == little.sign) ? (big_mag + small_mag)
                                             : (big_mag - small_mag);

  always_ff @(posedge clk, negedge rstnn)
  begin
    if (rstnn == 1'b0)
      o_raw <= '0;
    else if (i_start)
    begin
      o_raw.sign <= big.sign;
      o_raw.exp  <= {2'b00, big.exp};
      o_raw.mag  <= sum_mag;
    end
  end

endmodule

/* fpu_mul_path.sv */
/*
  FPU multiply path
  Sign XOR, biased exponent sum and full 24x24 significand product,
  registered on start
*/

module fpu_mul_path (
  input  logic                  clk,
  input  logic                  rstnn,
  input  logic                  i_start,
  input  fpu_pkg::fp_unpacked_t i_op_a,
  input  fpu_pkg::fp_unpacked_t i_op_b,
  output fpu_pkg::fp_raw_t      o_raw
);

  import fpu_pkg::*;

  logic [BW_RAW_EXP-1:0] exp_sum;
  logic [BW_RAW-1:0]     product;

  // One bias is removed so the result stays biased once
  assign exp_sum = {2'b00, i_op_a.exp} + {2'b00, i_op_b.exp} - BW_RAW_EXP'(EXP_BIAS);
  assign product = BW_RAW'(i_op_a.sig) * BW_RAW'(i_op_b.sig);

  always_ff @(posedge clk, negedge rstnn)
  begin
    if (rstnn == 1'b0)
      o_raw <= '0;
    else if (i_start)
    begin
      o_raw.sign <= i_op_a.sign ^ i_op_b.sign;
      o_raw.exp  <= exp_sum;
      o_raw.mag  <= product;
    end
  end

endmodule

/* fpu_norm_pack.sv */
/*
  FPU normalize and pack
  Picks the raw result for the current operation, normalizes on the
  leading one, truncates and packs an IEEE single-precision word
*/

module fpu_norm_pack (
  input  fpu_pkg::fpu_op_e i_op,
  input  fpu_pkg::fp_raw_t i_add_raw,
  input  fpu_pkg::fp_raw_t i_mul_raw,
  output logic [31:0]      o_packed
);

  import fpu_pkg::*;

  localparam int BW_LEAD = $clog2(BW_RAW);

  fp_raw_t               raw;
  logic [BW_LEAD-1:0]    lead;
  logic [BW_RAW-1:0]     norm_mag;
  logic [BW_RAW_EXP-1:0] norm_exp;
  logic [BW_MANT-1:0]    mant;

  assign raw = (i_op == OP_MUL) ? i_mul_raw : i_add_raw;

  // Leading one, highest set bit wins
  always_comb
  begin
    lead = '0;
    for (int i = 0; i < BW_RAW; i++)
    begin
      if (raw.mag[i])
        lead = BW_LEAD'(i);
    end
  end

  // Move the leading one to bit 47, zeros fill from below
  assign norm_mag = raw.mag << (BW_RAW - 1 - lead);
  assign mant     = norm_mag[BW_RAW-2 -: BW_MANT];

  // Binary point sits after bit 46
  assign norm_exp = raw.exp + BW_RAW_EXP'(lead) - BW_RAW_EXP'(BW_RAW - 2);

  always_comb
  begin
    if (raw.mag == '0)
      o_packed = '0;
    else
      o_packed = {raw.sign, norm_exp[BW_EXP-1:0], mant};
  end

endmodule

/* fpu_apb.sv */
/*
  Floating-point coprocessor with an APB slave port
  ADD, SUB and MUL on IEEE single-precision operands
*/

module fpu_apb #(
  parameter int BW_ADDR = 4
) (
  input  logic               clk,
  input  logic               rstnn,
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic [BW_ADDR-1:0] i_paddr,
  input  logic               i_pwrite,
  input  logic [31:0]        i_pwdata,
  output logic [31:0]        o_prdata,
  output logic               o_pready,
  output logic               o_pslverr
);

  import fpu_pkg::*;

  fpu_op_e      op;
  fp_unpacked_t op_a;
  fp_unpacked_t op_b;
  logic         start;
  fp_raw_t      add_raw;
  fp_raw_t      mul_raw;
  logic [31:0]  packed_word;

  fpu_apb_regs #(
    .BW_ADDR(BW_ADDR)
  ) regs_inst (
    .clk       (clk),
    .rstnn     (rstnn),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_paddr   (i_paddr),
    .i_pwrite  (i_pwrite),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .i_packed  (packed_word),
    .o_op      (op),
    .o_op_a    (op_a),
    .o_op_b    (op_b),
    .o_start   (start)
  );

  fpu_add_path add_path_inst (
    .clk     (clk),
    .rstnn   (rstnn),
    .i_start (start),
    .i_op    (op),
    .i_op_a  (op_a),
    .i_op_b  (op_b),
    .o_raw   (add_raw)
  );

  fpu_mul_path mul_path_inst (
    .clk     (clk),
    .rstnn   (rstnn),
    .i_start (start),
    .i_op_a  (op_a),
    .i_op_b  (op_b),
    .o_raw   (mul_raw)
  );

  fpu_norm_pack norm_pack_inst (
    .i_op      (op),
    .i_add_raw (add_raw),
    .i_mul_raw (mul_raw),
    .o_packed  (packed_word)
  );

endmodule

/* tb_fpu_model.svh */
/*
  FPU testbench reference model
  LFSR random source, IEEE single-precision model with truncation
  and the typed compare tasks
*/

  // **************************************************************************
  // Random source
  // **************************************************************************

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // **************************************************************************
  // Arithmetic model
  // **************************************************************************

  // Raw value is mag * 2**(exp_raw - 127 - 46)
  function automatic logic [31:0] pack_raw(input logic sign, input int exp_raw,
                                           input logic [63:0] mag);
    int          lead;
    int          exp_out;
    logic [63:0] aligned;
    if (mag == 64'd0)
      return 32'd0;
    lead = 63;
    while (mag[lead] == 1'b0)
      lead = lead - 1;
    exp_out = exp_raw + lead - 46;
    // Leading one lands on bit 23, bits under it form the mantissa
    if (lead >= 23)
      aligned = mag >> (lead - 23);
    else
      aligned = mag << (23 - lead);
    return {sign, exp_out[7:0], aligned[22:0]};
  endfunction

  function automatic logic [31:0] model_result(input fpu_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
    logic        sign_a;
    logic        sign_b;
    logic        sign_big;
    logic        sign_small;
    int          exp_a;
    int          exp_b;
    int          exp_big;
    int          exp_small;
    logic [63:0] sig_a;
    logic [63:0] sig_b;
    logic [63:0] sig_big;
    logic [63:0] sig_small;
    logic [63:0] mag;
    sign_a = a[31];
    sign_b = b[31];
    exp_a  = int'(a[30:23]);
    exp_b  = int'(b[30:23]);
    sig_a  = {40'd0, 1'b1, a[22:0]};
    sig_b  = {40'd0, 1'b1, b[22:0]};
    if (op == OP_MUL)
      return pack_raw(sign_a ^ sign_b, exp_a + exp_b - EXP_BIAS, sig_a * sig_b);
    if (op == OP_SUB)
      sign_b = ~sign_b;
    if ((exp_a > exp_b) || ((exp_a == exp_b) && (sig_a >= sig_b)))
    begin
      sign_big   = sign_a;
      exp_big    = exp_a;
      sig_big    = sig_a;
      sign_small = sign_b;
      exp_small  = exp_b;
      sig_small  = sig_b;
    end
    else
    begin
      sign_big   = sign_b;
      exp_big    = exp_b;
      sig_big    = sig_b;
      sign_small = sign_a;
      exp_small  = exp_a;
      sig_small  = sig_a;
    end
    // Bits shifted below bit 0 are lost
    mag = (sig_small << 23) >> (exp_big - exp_small);
    if (sign_big == sign_small)
      mag = (sig_big << 23) + mag;
    else
      mag = (sig_big << 23) - mag;
    return pack_raw(sign_big, exp_big, mag);
  endfunction

  // **************************************************************************
  // Compare tasks
  // **************************************************************************

  task automatic check_word(input string test, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s expected %h actual %h", test, expected, actual);
      value_errors = value_errors + 1;
    end
  endtask

  task automatic check_resp(input string test, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s pslverr expected %b actual %b", test, expected, actual);
      resp_errors = resp_errors + 1;
    end
  endtask

  // Busy bit follows the sequencer state
  task automatic check_status(input string test, input fpu_state_e state,
                              input logic [31:0] actual);
    logic [31:0] expected;
    expected = {31'd0, (state == ST_EXEC) || (state == ST_PACK)};
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s status expected %h actual %h", test, expected, actual);
      status_errors = status_errors + 1;
    end
  endtask

/* tb_fpu_apb.sv */
/*
  Testbench for the APB floating-point coprocessor
  Random ADD, SUB and MUL operations against a reference model,
  plus reset state, error responses and RESULT stalls
*/

module tb_fpu_apb;

  import fpu_pkg::*;

  localparam int BW_ADDR     = 4;
  localparam int N_RANDOM    = 200;
  // Three random batches plus the error and stall tests
  localparam int N_OPS       = 3 * N_RANDOM + 3;
  localparam int CYCLE_LIMIT = 12 * N_OPS + 200;

  logic               clk = 1'b0;
  logic               rstnn;
  logic               psel;
  logic               penable;
  logic [BW_ADDR-1:0] paddr;
  logic               pwrite;
  logic [31:0]        pwdata;
  logic [31:0]        prdata;
  logic               pready;
  logic               pslverr;

  logic [31:0] lfsr_state = 32'h41f2_70f3;
  int          value_errors = 0;
  int          resp_errors = 0;
  int          status_errors = 0;
  int          protocol_errors = 0;
  int          cycles = 0;

  `include "tb_fpu_model.svh"

  fpu_apb #(
    .BW_ADDR(BW_ADDR)
  ) fpu_apb_inst (
    .clk       (clk),
    .rstnn     (rstnn),
    .i_psel    (psel),
    .i_penable (penable),
    .i_paddr   (paddr),
    .i_pwrite  (pwrite),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // **************************************************************************
  // APB driver
  // **************************************************************************

  // Entered and left 1 unit after a rising edge, so transfers run back to back
  task automatic apb_access(input logic write, input logic [BW_ADDR-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int waits);
    waits   = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    // Ready is sampled mid-cycle
    @(negedge clk);
    while (!pready)
    begin
      waits = waits + 1;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic random_operand(input int exp_val, output logic [31:0] word);
    logic [31:0] s;
    logic [31:0] m;
    draw_bits(1, s);
    draw_bits(23, m);
    word = {s[0], exp_val[7:0], m[22:0]};
  endtask

  // Exponents 64..191, within 30 of each other for ADD and SUB
  task automatic random_pair(input fpu_op_e op, output logic [31:0] a,
                             output logic [31:0] b);
    logic [31:0] r;
    int          exp_a;
    int          exp_b;
    int          diff;
    draw_bits(7, r);
    exp_a = 64 + int'(r[6:0]);
    draw_bits(7, r);
    exp_b = 64 + int'(r[6:0]);
    if (op != OP_MUL)
    begin
      draw_bits(5, r);
      diff = int'(r[4:0]) % 31;
      draw_bits(1, r);
      if (r[0] && (exp_a + diff <= 191))
        exp_b = exp_a + diff;
      else if (exp_a - diff >= 64)
        exp_b = exp_a - diff;
      else
        exp_b = exp_a + diff;
    end
    random_operand(exp_a, a);
    random_operand(exp_b, b);
  endtask

  task automatic run_operation(input string test, input fpu_op_e op,
                               input logic [31:0] a, input logic [31:0] b);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_access(1'b1, BW_ADDR'(REG_CMD), 32'(op), rdata, err, waits);
    check_resp(test, 1'b0, err);
    apb_access(1'b1, BW_ADDR'(REG_OPERAND), a, rdata, err, waits);
    check_resp(test, 1'b0, err);
    apb_access(1'b1, BW_ADDR'(REG_OPERAND), b, rdata, err, waits);
    check_resp(test, 1'b0, err);
    apb_access(1'b0, BW_ADDR'(REG_RESULT), 32'd0, rdata, err, waits);
    check_resp(test, 1'b0, err);
    check_word($sformatf("%s a=%h b=%h", test, a, b), model_result(op, a, b), rdata);
  endtask

  // **************************************************************************
  // Test sequence
  // **************************************************************************

  initial
  begin : stimulus
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rdata;
    logic        err;
    int          waits;
    rstnn   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    paddr   = '0;
    pwrite  = 1'b0;
    pwdata  = '0;
    repeat (5) @(posedge clk);
    #1;
    rstnn = 1'b1;

    apb_access(1'b0, BW_ADDR'(REG_STATUS), 32'd0, rdata, err, waits);
    check_status("reset status", ST_IDLE, rdata);
    apb_access(1'b0, BW_ADDR'(REG_RESULT), 32'd0, rdata, err, waits);
    check_word("reset result", 32'd0, rdata);
    if (waits != 0)
    begin
      $display("RESULT read after reset stalled for %0d cycles", waits);
      protocol_errors = protocol_errors + 1;
    end

    for (int i = 0; i < N_RANDOM; i++)
    begin
      random_pair(OP_ADD, a, b);
      // Same magnitude with opposite sign now and then
      if (i % 16 == 5)
        b = {~a[31], a[30:0]};
      run_operation($sformatf("add %0d", i), OP_ADD, a, b);
    end

    for (int i = 0; i < N_RANDOM; i++)
    begin
      random_pair(OP_SUB, a, b);
      if (i % 8 == 3)
        b = a;
      run_operation($sformatf("sub %0d", i), OP_SUB, a, b);
    end

    for (int i = 0; i < N_RANDOM; i++)
    begin
      random_pair(OP_MUL, a, b);
      run_operation($sformatf("mul %0d", i), OP_MUL, a, b);
    end

    // Rejected accesses between the two operand writes
    random_pair(OP_MUL, a, b);
    apb_access(1'b1, BW_ADDR'(REG_CMD), 32'(OP_MUL), rdata, err, waits);
    check_resp("error test command", 1'b0, err);
    apb_access(1'b1, BW_ADDR'(REG_OPERAND), a, rdata, err, waits);
    apb_access(1'b1, BW_ADDR'(REG_CMD), 32'd3, rdata, err, waits);
    check_resp("illegal command", 1'b1, err);
    apb_access(1'b1, BW_ADDR'(7), 32'hffff_ffff, rdata, err, waits);
    check_resp("unmapped offset", 1'b1, err);
    apb_access(1'b1, BW_ADDR'(REG_OPERAND), b, rdata, err, waits);
    apb_access(1'b0, BW_ADDR'(REG_RESULT), 32'd0, rdata, err, waits);
    check_word("after rejected accesses", model_result(OP_MUL, a, b), rdata);

    // STATUS right after operand B
    random_pair(OP_ADD, a, b);
    apb_access(1'b1, BW_ADDR'(REG_CMD), 32'(OP_ADD), rdata, err, waits);
    apb_access(1'b1, BW_ADDR'(REG_OPERAND), a, rdata, err, waits);
    apb_access(1'b1, BW_ADDR'(REG_OPERAND), b, rdata, err, waits);
    apb_access(1'b0, BW_ADDR'(REG_STATUS), 32'd0, rdata, err, waits);
    check_status("status after operand B", ST_PACK, rdata);
    apb_access(1'b0, BW_ADDR'(REG_RESULT), 32'd0, rdata, err, waits);
    check_word("result after status", model_result(OP_ADD, a, b), rdata);

    // RESULT right after operand B has to wait
    random_pair(OP_SUB, a, b);
    apb_access(1'b1, BW_ADDR'(REG_CMD), 32'(OP_SUB), rdata, err, waits);
    apb_access(1'b1, BW_ADDR'(REG_OPERAND), a, rdata, err, waits);
    apb_access(1'b1, BW_ADDR'(REG_OPERAND), b, rdata, err, waits);
    apb_access(1'b0, BW_ADDR'(REG_RESULT), 32'd0, rdata, err, waits);
    check_word("stalled result", model_result(OP_SUB, a, b), rdata);
    if (waits == 0)
    begin
      $display("RESULT read right after operand B completed without a stall");
      protocol_errors = protocol_errors + 1;
    end

    $display("Errors: value %0d, response %0d, status %0d, protocol %0d",
             value_errors, resp_errors, status_errors, protocol_errors);
    if (value_errors + resp_errors + status_errors + protocol_errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* src.f */
+incdir+.
fpu_pkg.sv
fpu_apb_regs.sv
fpu_add_path.sv
fpu_mul_path.sv
fpu_norm_pack.sv
fpu_apb.sv
tb_fpu_apb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the FPU APB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_fpu_apb -o sim_fpu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_fpu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1
